// File: ring_router_pkg.sv
package ring_router_pkg;

	// --------------------
	// Field widths
	// --------------------

	localparam int PKT_W = 64;
	localparam int HOP_W = 8;
	localparam int SRC_W = 16;
	localparam int DATA_W = 32;

	// Whatever is left after vc, dir and the wide fields
	localparam int RSV_W = PKT_W - 2 - HOP_W - SRC_W - DATA_W;

	// Even and odd channel per port side
	localparam int NUM_VC = 2;

	// --------------------
	// Hop codes
	// --------------------

	// Legal pe injection hops, thermometer coded
	localparam logic [HOP_W-1:0] HOP_ONE = 8'b0000_0001;
	localparam logic [HOP_W-1:0] HOP_TWO = 8'b0000_0011;
	localparam logic [HOP_W-1:0] HOP_THREE = 8'b0000_0111;

	// --------------------
	// Port indices
	// --------------------

	typedef enum logic [1:0] {
		PORT_CW = 2'd0,
		PORT_CCW = 2'd1,
		PORT_PE = 2'd2
	} port_e;

	// --------------------
	// Packet layout
	// --------------------

	// Bit 63 is vc, bit 62 is dir, hop sits at 55:48
	typedef struct packed {
		logic vc;
		logic dir;
		logic [RSV_W-1:0] rsv;
		logic [HOP_W-1:0] hop;
		logic [SRC_W-1:0] src;
		logic [DATA_W-1:0] data;
	} packet_t;

endpackage

// File: pe_inject.sv
module pe_inject (
	input  ring_router_pkg::packet_t pkt,
	output ring_router_pkg::packet_t fixed,
	output logic malformed
);

	// Injected packets may only ask for one to three hops.
	// Two hops go clockwise whatever the pe asked for, and three hops
	// are turned into one hop the other way round the ring.
	always_comb begin
		fixed = pkt;
		malformed = 1'b0;
		case (pkt.hop)
			ring_router_pkg::HOP_ONE: begin
				// Neighbour in the requested direction
				fixed = pkt;
			end
			ring_router_pkg::HOP_TWO: begin
				// Either way is as short, pick cw
				fixed.dir = 1'b1;
			end
			ring_router_pkg::HOP_THREE: begin
				// Shorter going the other way
				fixed.dir = ~pkt.dir;
				fixed.hop = ring_router_pkg::HOP_ONE;
			end
			default: begin
				// Not a legal thermometer code for injection
				malformed = 1'b1;
			end
		endcase
	end

endmodule

// File: vc_slot_pair.sv
module vc_slot_pair (
	input  logic clk,
	input  logic reset,
	input  logic polarity,
	input  logic wr_en,
	input  logic rd_ext,
	input  ring_router_pkg::packet_t wr_pkt,
	input  logic int_rd,
	input  logic int_wr,
	input  ring_router_pkg::packet_t int_pkt,
	output logic ext_full,
	output logic int_full,
	output ring_router_pkg::packet_t ext_pkt,
	output ring_router_pkg::packet_t int_pkt_out
);

	ring_router_pkg::packet_t slot [ring_router_pkg::NUM_VC];
	logic [ring_router_pkg::NUM_VC-1:0] full;
	ring_router_pkg::packet_t stamped;
	logic ext_sel;
	logic int_sel;

	// Outside world uses the current channel, the switch the other one
	assign ext_sel = polarity;
	assign int_sel = ~polarity;

	// Packet takes the channel it was written on
	always_comb begin
		stamped = wr_pkt;
		stamped.vc = polarity;
	end

	// --------------------
	// Full flags
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= '0;
		end else begin
			if (wr_en) begin
				full[ext_sel] <= 1'b1;
			end else if (rd_ext) begin
				full[ext_sel] <= 1'b0;
			end
			if (int_wr) begin
				full[int_sel] <= 1'b1;
			end else if (int_rd) begin
				full[int_sel] <= 1'b0;
			end
		end
	end

	// --------------------
	// Packet storage
	// --------------------

	always_ff @(posedge clk) begin
		if (wr_en) begin
			slot[ext_sel] <= stamped;
		end
		if (int_wr) begin
			slot[int_sel] <= int_pkt;
		end
	end

	assign ext_full = full[ext_sel];
	assign int_full = full[int_sel];
	assign ext_pkt = slot[ext_sel];
	assign int_pkt_out = slot[int_sel];

endmodule

// File: rr_arbiter.sv
module rr_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic [1:0] req,
	output logic [1:0] grant
);

	// Low favours req[0], high favours req[1]
	logic prio;

	// Same-cycle grant, the favoured side wins a tie
	always_comb begin
		grant = 2'b00;
		if (req[0] && (!prio || !req[1])) begin
			grant[0] = 1'b1;
		end else if (req[1]) begin
			grant[1] = 1'b1;
		end
	end

	// --------------------
	// Priority update
	// --------------------

	// The winner drops to the back
	always_ff @(posedge clk) begin
		if (reset) begin
			prio <= 1'b0;
		end else if (grant[0]) begin
			prio <= 1'b1;
		end else if (grant[1]) begin
			prio <= 1'b0;
		end
	end

endmodule

// File: switch_core.sv
module switch_core (
	input  logic clk,
	input  logic reset,
	input  logic [2:0] in_full,
	input  ring_router_pkg::packet_t in_pkt [3],
	input  logic [2:0] out_full,
	output logic [2:0] in_rd,
	output logic [2:0] out_wr,
	output ring_router_pkg::packet_t out_pkt [3]
);

	// One hop taken, thermometer shrinks by one
	function automatic ring_router_pkg::packet_t hop_step(input ring_router_pkg::packet_t p);
		ring_router_pkg::packet_t q;
		q = p;
		q.hop = p.hop >> 1;
		return q;
	endfunction

	logic cw_stay;
	logic ccw_stay;
	logic pe_to_cw;
	logic [1:0] cw_req;
	logic [1:0] ccw_req;
	logic [1:0] pe_req;
	logic [1:0] cw_gnt;
	logic [1:0] ccw_gnt;
	logic [1:0] pe_gnt;
	ring_router_pkg::packet_t cw_step;
	ring_router_pkg::packet_t ccw_step;

	// --------------------
	// Route computation
	// --------------------

	// Ring packets keep going while hop bit 0 is set, else they are home
	assign cw_stay = in_pkt[ring_router_pkg::PORT_CW].hop[0];
	assign ccw_stay = in_pkt[ring_router_pkg::PORT_CCW].hop[0];

	// pe packets follow their direction bit
	assign pe_to_cw = in_pkt[ring_router_pkg::PORT_PE].dir;

	// --------------------
	// Requests
	// --------------------

	// Slot 0 of each arbiter is the ring input on that side
	assign cw_req[0] = in_full[ring_router_pkg::PORT_CW] && cw_stay
		&& !out_full[ring_router_pkg::PORT_CW];
	assign cw_req[1] = in_full[ring_router_pkg::PORT_PE] && pe_to_cw
		&& !out_full[ring_router_pkg::PORT_CW];

	assign ccw_req[0] = in_full[ring_router_pkg::PORT_CCW] && ccw_stay
		&& !out_full[ring_router_pkg::PORT_CCW];
	assign ccw_req[1] = in_full[ring_router_pkg::PORT_PE] && !pe_to_cw
		&& !out_full[ring_router_pkg::PORT_CCW];

	assign pe_req[0] = in_full[ring_router_pkg::PORT_CW] && !cw_stay
		&& !out_full[ring_router_pkg::PORT_PE];
	assign pe_req[1] = in_full[ring_router_pkg::PORT_CCW] && !ccw_stay
		&& !out_full[ring_router_pkg::PORT_PE];

	// --------------------
	// Arbiters
	// --------------------

	rr_arbiter cw_arb (
		.clk(clk),
		.reset(reset),
		.req(cw_req),
		.grant(cw_gnt)
	);

	rr_arbiter ccw_arb (
		.clk(clk),
		.reset(reset),
		.req(ccw_req),
		.grant(ccw_gnt)
	);

	rr_arbiter pe_arb (
		.clk(clk),
		.reset(reset),
		.req(pe_req),
		.grant(pe_gnt)
	);

	// --------------------
	// Moves
	// --------------------

	// Each input requests only one output, so at most one grant per input
	assign in_rd[ring_router_pkg::PORT_CW] = cw_gnt[0] | pe_gnt[0];
	assign in_rd[ring_router_pkg::PORT_CCW] = ccw_gnt[0] | pe_gnt[1];
	assign in_rd[ring_router_pkg::PORT_PE] = cw_gnt[1] | ccw_gnt[1];

	assign out_wr[ring_router_pkg::PORT_CW] = |cw_gnt;
	assign out_wr[ring_router_pkg::PORT_CCW] = |ccw_gnt;
	assign out_wr[ring_router_pkg::PORT_PE] = |pe_gnt;

	assign cw_step = hop_step(in_pkt[ring_router_pkg::PORT_CW]);
	assign ccw_step = hop_step(in_pkt[ring_router_pkg::PORT_CCW]);

	// Injected packets enter the ring with their hop field as normalized
	assign out_pkt[ring_router_pkg::PORT_CW] = cw_gnt[1]
		? in_pkt[ring_router_pkg::PORT_PE] : cw_step;
	assign out_pkt[ring_router_pkg::PORT_CCW] = ccw_gnt[1]
		? in_pkt[ring_router_pkg::PORT_PE] : ccw_step;
	assign out_pkt[ring_router_pkg::PORT_PE] = pe_gnt[1] ? ccw_step : cw_step;

endmodule

// File: ring_router.sv
module ring_router (
	input  logic clk,
	input  logic reset,
	input  logic polarity,
	input  ring_router_pkg::packet_t cw_in,
	input  ring_router_pkg::packet_t ccw_in,
	input  ring_router_pkg::packet_t pe_in,
	input  logic cw_send_in,
	input  logic ccw_send_in,
	input  logic pe_send_in,
	output logic cw_ready_in,
	output logic ccw_ready_in,
	output logic pe_ready_in,
	output ring_router_pkg::packet_t cw_out,
	output ring_router_pkg::packet_t ccw_out,
	output ring_router_pkg::packet_t pe_out,
	output logic cw_send_out,
	output logic ccw_send_out,
	output logic pe_send_out,
	input  logic cw_ready_out,
	input  logic ccw_ready_out,
	input  logic pe_ready_out
);

	logic [2:0] in_ext_full;
	logic [2:0] in_full;
	logic [2:0] out_full;
	logic [2:0] in_rd;
	logic [2:0] out_wr;
	ring_router_pkg::packet_t in_pkt [3];
	ring_router_pkg::packet_t out_pkt [3];
	ring_router_pkg::packet_t pe_fixed;
	logic pe_malformed;

	// Ready only reflects slot state, never the incoming data
	assign cw_ready_in = !in_ext_full[ring_router_pkg::PORT_CW];
	assign ccw_ready_in = !in_ext_full[ring_router_pkg::PORT_CCW];
	assign pe_ready_in = !in_ext_full[ring_router_pkg::PORT_PE];

	pe_inject pe_inj (
		.pkt(pe_in),
		.fixed(pe_fixed),
		.malformed(pe_malformed)
	);

	// --------------------
	// Input slots
	// --------------------

	vc_slot_pair cw_in_slots (
		.clk(clk), .reset(reset), .polarity(polarity),
		.wr_en(cw_send_in && cw_ready_in), .rd_ext(1'b0), .wr_pkt(cw_in),
		.int_rd(in_rd[ring_router_pkg::PORT_CW]), .int_wr(1'b0), .int_pkt('0),
		.ext_full(in_ext_full[ring_router_pkg::PORT_CW]),
		.int_full(in_full[ring_router_pkg::PORT_CW]),
		.ext_pkt(), .int_pkt_out(in_pkt[ring_router_pkg::PORT_CW])
	);

	vc_slot_pair ccw_in_slots (
		.clk(clk), .reset(reset), .polarity(polarity),
		.wr_en(ccw_send_in && ccw_ready_in), .rd_ext(1'b0), .wr_pkt(ccw_in),
		.int_rd(in_rd[ring_router_pkg::PORT_CCW]), .int_wr(1'b0), .int_pkt('0),
		.ext_full(in_ext_full[ring_router_pkg::PORT_CCW]),
		.int_full(in_full[ring_router_pkg::PORT_CCW]),
		.ext_pkt(), .int_pkt_out(in_pkt[ring_router_pkg::PORT_CCW])
	);

	// Malformed packets are taken off the port but never stored
	vc_slot_pair pe_in_slots (
		.clk(clk), .reset(reset), .polarity(polarity),
		.wr_en(pe_send_in && pe_ready_in && !pe_malformed), .rd_ext(1'b0),
		.wr_pkt(pe_fixed),
		.int_rd(in_rd[ring_router_pkg::PORT_PE]), .int_wr(1'b0), .int_pkt('0),
		.ext_full(in_ext_full[ring_router_pkg::PORT_PE]),
		.int_full(in_full[ring_router_pkg::PORT_PE]),
		.ext_pkt(), .int_pkt_out(in_pkt[ring_router_pkg::PORT_PE])
	);

	switch_core core (
		.clk(clk),
		.reset(reset),
		.in_full(in_full),
		.in_pkt(in_pkt),
		.out_full(out_full),
		.in_rd(in_rd),
		.out_wr(out_wr),
		.out_pkt(out_pkt)
	);

	// --------------------
	// Output slots
	// --------------------

	// A full slot on the current channel is the send strobe
	vc_slot_pair cw_out_slots (
		.clk(clk), .reset(reset), .polarity(polarity),
		.wr_en(1'b0), .rd_ext(cw_send_out && cw_ready_out), .wr_pkt('0),
		.int_rd(1'b0), .int_wr(out_wr[ring_router_pkg::PORT_CW]),
		.int_pkt(out_pkt[ring_router_pkg::PORT_CW]),
		.ext_full(cw_send_out), .int_full(out_full[ring_router_pkg::PORT_CW]),
		.ext_pkt(cw_out), .int_pkt_out()
	);

	vc_slot_pair ccw_out_slots (
		.clk(clk), .reset(reset), .polarity(polarity),
		.wr_en(1'b0), .rd_ext(ccw_send_out && ccw_ready_out), .wr_pkt('0),
		.int_rd(1'b0), .int_wr(out_wr[ring_router_pkg::PORT_CCW]),
		.int_pkt(out_pkt[ring_router_pkg::PORT_CCW]),
		.ext_full(ccw_send_out), .int_full(out_full[ring_router_pkg::PORT_CCW]),
		.ext_pkt(ccw_out), .int_pkt_out()
	);

	vc_slot_pair pe_out_slots (
		.clk(clk), .reset(reset), .polarity(polarity),
		.wr_en(1'b0), .rd_ext(pe_send_out && pe_ready_out), .wr_pkt('0),
		.int_rd(1'b0), .int_wr(out_wr[ring_router_pkg::PORT_PE]),
		.int_pkt(out_pkt[ring_router_pkg::PORT_PE]),
		.ext_full(pe_send_out), .int_full(out_full[ring_router_pkg::PORT_PE]),
		.ext_pkt(pe_out), .int_pkt_out()
	);

endmodule

// File: ring_router_chk.sv
module ring_router_chk (
	input logic clk,
	input logic reset,
	input logic cw_send_out,
	input logic ccw_send_out,
	input logic pe_send_out,
	input logic cw_ready_out,
	input logic ccw_ready_out,
	input logic pe_ready_out,
	input logic [1:0] cw_req,
	input logic [1:0] ccw_req,
	input logic [1:0] pe_req,
	input logic [1:0] cw_gnt,
	input logic [1:0] ccw_gnt,
	input logic [1:0] pe_gnt
);

	timeunit 1ns;
	timeprecision 100ps;

	// --------------------
	// Port protocol
	// --------------------

	// A held packet is shown again when its channel comes round
	hold_cw: assert property (@(posedge clk) disable iff (reset)
		(cw_send_out && !cw_ready_out) |-> ##2 cw_send_out)
		else $error("cw send_out dropped while stalled");
	hold_ccw: assert property (@(posedge clk) disable iff (reset)
		(ccw_send_out && !ccw_ready_out) |-> ##2 ccw_send_out)
		else $error("ccw send_out dropped while stalled");
	hold_pe: assert property (@(posedge clk) disable iff (reset)
		(pe_send_out && !pe_ready_out) |-> ##2 pe_send_out)
		else $error("pe send_out dropped while stalled");

	// --------------------
	// Arbiter grants
	// --------------------

	// A requester passed over for the other one wins its next request
	// when no grant came in between
	cw_turn: assert property (@(posedge clk) disable iff (reset)
		(($past(cw_gnt) == 2'b00) && (($past(cw_req & ~cw_gnt, 2) & cw_req) != 2'b00))
		|-> (cw_gnt == $past(cw_req & ~cw_gnt, 2)))
		else $error("cw arbiter passed over the same requester twice");
	ccw_turn: assert property (@(posedge clk) disable iff (reset)
		(($past(ccw_gnt) == 2'b00) && (($past(ccw_req & ~ccw_gnt, 2) & ccw_req) != 2'b00))
		|-> (ccw_gnt == $past(ccw_req & ~ccw_gnt, 2)))
		else $error("ccw arbiter passed over the same requester twice");
	pe_turn: assert property (@(posedge clk) disable iff (reset)
		(($past(pe_gnt) == 2'b00) && (($past(pe_req & ~pe_gnt, 2) & pe_req) != 2'b00))
		|-> (pe_gnt == $past(pe_req & ~pe_gnt, 2)))
		else $error("pe arbiter passed over the same requester twice");

endmodule

// File: tb_ring_router.sv
module tb_ring_router;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_ENTRIES = 12;
	localparam int RESET_CYCLES = 16;
	localparam int CYCLE_LIMIT = NUM_ENTRIES * 40 + RESET_CYCLES;

	typedef struct packed {
		logic [1:0] src_port;
		logic [1:0] dst_port;
		logic discard;
		logic stall;
		logic with_next;
		ring_router_pkg::packet_t pkt;
		ring_router_pkg::packet_t exp;
	} entry_t;

	typedef struct packed {
		logic [1:0] port;
		ring_router_pkg::packet_t pkt;
	} rx_t;

	logic clk = 1'b0;
	logic reset;
	logic polarity;
	logic [2:0] send_in;
	logic [2:0] ready_in;
	logic [2:0] send_out;
	logic [2:0] ready_out;
	ring_router_pkg::packet_t in_pkt [3];
	ring_router_pkg::packet_t out_pkt [3];
	entry_t table_e [NUM_ENTRIES];
	rx_t rx_q [$];
	integer seed = 67815;
	int cycles = 0;
	int errors = 0;
	int mismatches = 0;
	int missing = 0;

	ring_router UUT (
		.clk(clk), .reset(reset), .polarity(polarity),
		.cw_in(in_pkt[0]), .ccw_in(in_pkt[1]), .pe_in(in_pkt[2]),
		.cw_send_in(send_in[0]), .ccw_send_in(send_in[1]), .pe_send_in(send_in[2]),
		.cw_ready_in(ready_in[0]), .ccw_ready_in(ready_in[1]), .pe_ready_in(ready_in[2]),
		.cw_out(out_pkt[0]), .ccw_out(out_pkt[1]), .pe_out(out_pkt[2]),
		.cw_send_out(send_out[0]), .ccw_send_out(send_out[1]), .pe_send_out(send_out[2]),
		.cw_ready_out(ready_out[0]), .ccw_ready_out(ready_out[1]),
		.pe_ready_out(ready_out[2])
	);

	bind ring_router ring_router_chk chk (
		.clk(clk), .reset(reset),
		.cw_send_out(cw_send_out), .ccw_send_out(ccw_send_out), .pe_send_out(pe_send_out),
		.cw_ready_out(cw_ready_out), .ccw_ready_out(ccw_ready_out),
		.pe_ready_out(pe_ready_out),
		.cw_req(core.cw_req), .ccw_req(core.ccw_req), .pe_req(core.pe_req),
		.cw_gnt(core.cw_gnt), .ccw_gnt(core.ccw_gnt), .pe_gnt(core.pe_gnt)
	);

	always #4 clk = ~clk;

	// Channel flips every cycle
	always begin
		@(posedge clk);
		#1;
		polarity = ~polarity;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the run did not complete", cycles);
			$display("Test failures found");
			$finish;
		end
	end

	// A packet leaves on the edge after a cycle with send and ready high
	always @(negedge clk) begin
		for (int p = 0; p < 3; p++) begin
			if (!reset && send_out[p] && ready_out[p]) begin
				rx_q.push_back('{port: 2'(p), pkt: out_pkt[p]});
			end
		end
	end

	function automatic entry_t make_entry(input logic [1:0] src, input logic [1:0] dst,
		input logic [7:0] hop_in, input logic dir_in, input logic [7:0] hop_exp,
		input logic dir_exp, input logic discard, input logic stall, input logic with_next);
		entry_t e;
		e.src_port = src;
		e.dst_port = dst;
		e.discard = discard;
		e.stall = stall;
		e.with_next = with_next;
		e.pkt = {$random(seed), $random(seed)};
		e.pkt.hop = hop_in;
		e.pkt.dir = dir_in;
		e.exp = e.pkt;
		e.exp.hop = hop_exp;
		e.exp.dir = dir_exp;
		return e;
	endfunction

	// Hold send until the port takes the packet and return the channel used
	task automatic drive_packet(input int port, input ring_router_pkg::packet_t p,
		output logic pol);
		logic taken;
		taken = 1'b0;
		@(posedge clk);
		#1;
		in_pkt[port] = p;
		send_in[port] = 1'b1;
		while (!taken) begin
			@(negedge clk);
			if (ready_in[port]) begin
				taken = 1'b1;
				pol = polarity;
			end
		end
		@(posedge clk);
		#1;
		send_in[port] = 1'b0;
	endtask

	task automatic check_stall(input int port);
		ring_router_pkg::packet_t held;
		int waited;
		waited = 0;
		@(negedge clk);
		while (!send_out[port] && waited < 30) begin
			@(negedge clk);
			waited++;
		end
		held = out_pkt[port];
		repeat (4) begin
			@(negedge clk);
			@(negedge clk);
			if (!send_out[port] || out_pkt[port] != held) begin
				$display("MISMATCH at %0t: stalled port %0d lost its packet", $time, port);
				mismatches++;
			end
		end
		@(posedge clk);
		#1;
		ready_out[port] = 1'b1;
	endtask

	task automatic run_entry(input int i, input int n);
		logic pol0;
		logic pol1;
		ring_router_pkg::packet_t exp_pkt [2];
		int waited;
		int hit;
		pol0 = 1'b0;
		pol1 = 1'b0;
		if (table_e[i].stall) begin
			@(posedge clk);
			#1;
			ready_out[table_e[i].dst_port] = 1'b0;
		end
		fork
			drive_packet(table_e[i].src_port, table_e[i].pkt, pol0);
			begin
				if (n == 2) drive_packet(table_e[i+1].src_port, table_e[i+1].pkt, pol1);
			end
		join
		exp_pkt[0] = table_e[i].exp;
		exp_pkt[0].vc = pol0;
		if (n == 2) begin
			exp_pkt[1] = table_e[i+1].exp;
			exp_pkt[1].vc = pol1;
		end
		if (table_e[i].discard) begin
			repeat (12) @(posedge clk);
			if (rx_q.size() != 0) begin
				$display("Entry %0d: a malformed pe packet came out of the router", i);
				errors++;
			end
		end else begin
			if (table_e[i].stall) check_stall(table_e[i].dst_port);
			waited = 0;
			while (rx_q.size() < n && waited < 30) begin
				@(posedge clk);
				waited++;
			end
			for (int k = 0; k < n; k++) begin
				hit = -1;
				foreach (rx_q[j]) begin
					if (hit < 0 && rx_q[j].port == table_e[i+k].dst_port
						&& rx_q[j].pkt == exp_pkt[k]) hit = j;
				end
				if (hit >= 0) begin
					rx_q.delete(hit);
				end else if (rx_q.size() == 0) begin
					$display("Entry %0d: the packet never arrived", i + k);
					missing++;
				end else begin
					$display("MISMATCH at %0t: entry %0d expected %h on port %0d, got %h",
						$time, i + k, exp_pkt[k], table_e[i+k].dst_port, rx_q[0].pkt);
					mismatches++;
				end
			end
		end
		if (rx_q.size() != 0) begin
			$display("Entry %0d: %0d unexpected packets came out", i, rx_q.size());
			errors++;
		end
		rx_q.delete();
	endtask

	initial begin
		int i;
		reset = 1'b1;
		polarity = 1'b0;
		send_in = '0;
		ready_out = '1;
		for (int p = 0; p < 3; p++) in_pkt[p] = '0;

		// Ring traffic, then pe injection, then stall and contention
		table_e[0] = make_entry(0, 0, 8'b0000_0011, 1, 8'b0000_0001, 1, 0, 0, 0);
		table_e[1] = make_entry(1, 1, 8'b0000_0111, 0, 8'b0000_0011, 0, 0, 0, 0);
		table_e[2] = make_entry(0, 2, 8'b0000_0000, 1, 8'b0000_0000, 1, 0, 0, 0);
		table_e[3] = make_entry(1, 2, 8'b0000_0010, 0, 8'b0000_0001, 0, 0, 0, 0);
		table_e[4] = make_entry(2, 0, 8'b0000_0001, 1, 8'b0000_0001, 1, 0, 0, 0);
		table_e[5] = make_entry(2, 1, 8'b0000_0001, 0, 8'b0000_0001, 0, 0, 0, 0);
		table_e[6] = make_entry(2, 0, 8'b0000_0011, 0, 8'b0000_0011, 1, 0, 0, 0);
		table_e[7] = make_entry(2, 1, 8'b0000_0111, 1, 8'b0000_0001, 0, 0, 0, 0);
		table_e[8] = make_entry(2, 0, 8'b0000_1111, 1, 8'b0000_1111, 1, 1, 0, 0);
		table_e[9] = make_entry(0, 0, 8'b0000_0001, 1, 8'b0000_0000, 1, 0, 1, 0);
		table_e[10] = make_entry(0, 0, 8'b0000_0011, 1, 8'b0000_0001, 1, 0, 0, 1);
		table_e[11] = make_entry(2, 0, 8'b0000_0001, 1, 8'b0000_0001, 1, 0, 0, 0);

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		// Empty router after reset
		@(negedge clk);
		if (ready_in !== 3'b111 || send_out !== 3'b000) begin
			$display("MISMATCH at %0t: after reset ready_in=%b send_out=%b, expected 111 and 000",
				$time, ready_in, send_out);
			mismatches++;
		end

		i = 0;
		while (i < NUM_ENTRIES) begin
			if (table_e[i].with_next && i + 1 < NUM_ENTRIES) begin
				run_entry(i, 2);
				i += 2;
			end else begin
				run_entry(i, 1);
				i++;
			end
		end

		errors += mismatches + missing;
		$display("Errors: %0d total, %0d mismatches, %0d missing", errors, mismatches, missing);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: ring_router.f
ring_router_pkg.sv
pe_inject.sv
vc_slot_pair.sv
rr_arbiter.sv
switch_core.sv
ring_router.sv
ring_router_chk.sv
tb_ring_router.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ring router testbench with Verilator
verilator --binary --timing --assert --top-module tb_ring_router \
	-f ring_router.f -o sim_ring_router > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_ring_router > sim.log 2>&1 \
	|| { echo "Simulation exited with an error, see sim.log"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
